/* verilog/uart_bridge_consts.svh */
// shared constants of the uart bridge, included by the rtl and the testbench
`ifndef UART_BRIDGE_CONSTS_SVH
`define UART_BRIDGE_CONSTS_SVH

// clocks per serial bit
`define UART_OVERSAMPLE 4

// byte memory address width, depth is 2**MEM_ADDR_W
`define MEM_ADDR_W 8

// command bytes, ascii
`define CMD_LEN   8'h6c
`define CMD_ADDR  8'h61
`define CMD_READ  8'h72
`define CMD_WRITE 8'h77

// acknowledgement "OK\r"
`define ACK_0 8'h4f
`define ACK_1 8'h4b
`define ACK_2 8'h0d

`endif

/* verilog/uart_bridge_pkg.sv */
// types shared by the uart bridge modules, referenced by scoped name

package uart_bridge_pkg;

  // command controller states
  typedef enum logic [2:0] {
    IDLE,
    SET_LEN,
    SET_ADDR,
    READ,
    WRITE,
    ACK
  } bridge_state_t;

  // address and length words, loaded per byte and used whole
  typedef union packed {
    logic [3:0][7:0] bytes; // byte 0 is least significant
    logic [31:0]     word;
  } param_word_t;

endpackage

/* verilog/uart_bridge_if.sv */
// bundles between the command controller and the parameter registers and the byte memory
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

// bytewise parameter loading, the new word shows up the cycle after a strobe
interface param_if;
  logic                        load_len;
  logic                        load_addr;
  logic [1:0]                  byte_idx;
  logic [7:0]                  byte_val;
  uart_bridge_pkg::param_word_t len;
  uart_bridge_pkg::param_word_t addr;

  modport ctrl (
    output load_len, load_addr, byte_idx, byte_val,
    input  len, addr
  );

  modport regs (
    input  load_len, load_addr, byte_idx, byte_val,
    output len, addr
  );
endinterface

// bridge bus to the byte memory, rd returns rdata one cycle later
interface mem_if;
  logic [`MEM_ADDR_W-1:0] addr;
  logic [7:0]             wdata;
  logic                   wr;
  logic                   rd;
  logic [7:0]             rdata;

  modport master (
    output addr, wdata, wr, rd,
    input  rdata
  );

  modport slave (
    input  addr, wdata, wr, rd,
    output rdata
  );
endinterface

/* verilog/uart_rx.sv */
// serial receiver of the bridge, turns host frames into one-cycle byte strobes
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

module uart_rx (
  input  logic       clk,
  input  logic       UART_RST,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_data
);

  localparam int OVS = `UART_OVERSAMPLE;
  localparam int CW  = $clog2(OVS);

  logic          rx_meta;
  logic          rx_sync;
  logic          rx_prev;
  logic          busy;
  logic [CW-1:0] sample_cnt;
  logic [3:0]    bit_cnt;    // 0 start, 1..8 data, 9 stop
  logic [7:0]    shift;
  logic          mid_bit;

  assign mid_bit = busy && (sample_cnt == CW'(OVS / 2));
  assign rx_data = shift;

  // two flop synchronizer, idle line is high
  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      busy       <= 1'b0;
      sample_cnt <= '0;
      bit_cnt    <= '0;
      rx_valid   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (rx_prev && !rx_sync) begin // start edge counts as sample 0
          busy       <= 1'b1;
          sample_cnt <= CW'(1);
          bit_cnt    <= '0;
        end
      end else begin
        if (sample_cnt == CW'(OVS - 1)) begin
          sample_cnt <= '0;
          bit_cnt    <= bit_cnt + 4'd1;
        end else begin
          sample_cnt <= sample_cnt + 1'b1;
        end
        if (mid_bit && bit_cnt == 4'd0 && rx_sync) begin
          busy <= 1'b0; // glitch, no real start bit
        end else if (mid_bit && bit_cnt == 4'd9) begin
          busy     <= 1'b0;
          rx_valid <= rx_sync; // low stop bit drops the byte
        end
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (mid_bit && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

endmodule

/* verilog/uart_tx.sv */
// serial transmitter of the bridge, sends one byte per start strobe and flags busy
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

module uart_tx (
  input  logic       clk,
  input  logic       UART_RST,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  output logic       tx,
  output logic       tx_busy
);

  localparam int OVS = `UART_OVERSAMPLE;
  localparam int CW  = $clog2(OVS);

  logic [9:0]    frame;      // stop, data, start; shifted out from bit 0
  logic [CW-1:0] sample_cnt;
  logic [3:0]    bit_cnt;

  assign tx = frame[0]; // all ones when idle

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      frame      <= '1;
      tx_busy    <= 1'b0;
      sample_cnt <= '0;
      bit_cnt    <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        frame      <= {1'b1, tx_data, 1'b0};
        tx_busy    <= 1'b1;
        sample_cnt <= '0;
        bit_cnt    <= '0;
      end
    end else if (sample_cnt == CW'(OVS - 1)) begin
      sample_cnt <= '0;
      frame      <= {1'b1, frame[9:1]};
      bit_cnt    <= bit_cnt + 4'd1;
      if (bit_cnt == 4'd9) begin
        tx_busy <= 1'b0; // stop bit done
      end
    end else begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

endmodule

/* verilog/uart_param_regs.sv */
// start address and block length registers, loaded one byte at a time by the controller
`timescale 1ns/1ps

module uart_param_regs (
  input  logic  clk,
  input  logic  UART_RST,
  param_if.regs p
);

  uart_bridge_pkg::param_word_t len_q;
  uart_bridge_pkg::param_word_t addr_q;

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      len_q.word  <= 32'd1; // one byte blocks by default
      addr_q.word <= 32'd0;
    end else begin
      if (p.load_len) begin
        len_q.bytes[p.byte_idx] <= p.byte_val;
      end
      if (p.load_addr) begin
        addr_q.bytes[p.byte_idx] <= p.byte_val;
      end
    end
  end

  // controller only looks at whole words
  assign p.len  = len_q;
  assign p.addr = addr_q;

endmodule

/* verilog/uart_cmd_ctrl.sv */
// command FSM of the bridge, runs parameter loads, block writes, block reads and the ack
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

module uart_cmd_ctrl (
  input  logic       clk,
  input  logic       UART_RST,
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  input  logic       tx_busy,
  output logic       tx_start,
  output logic [7:0] tx_data,
  param_if.ctrl      p,
  mem_if.master      m
);

  localparam logic [1:0] RD_REQ  = 2'd0; // wait for tx idle, then issue rd
  localparam logic [1:0] RD_WAIT = 2'd1; // memory read in flight
  localparam logic [1:0] RD_SEND = 2'd2; // rdata valid, hand to tx

  uart_bridge_pkg::bridge_state_t state;
  logic [31:0] cnt;      // parameter byte, data byte or ack byte index
  logic [1:0]  rd_phase;
  logic        tx_free;
  logic        cnt_done;
  logic [7:0]  ack_byte;

  assign tx_free  = !tx_busy && !tx_start; // busy rises a cycle after start
  assign cnt_done = (cnt == p.len.word);

  always_comb begin
    case (cnt[1:0])
      2'd0:    ack_byte = `ACK_0;
      2'd1:    ack_byte = `ACK_1;
      default: ack_byte = `ACK_2;
    endcase
  end

  // loads and writes act on the receive strobe itself
  assign p.load_len  = (state == uart_bridge_pkg::SET_LEN) && rx_valid;
  assign p.load_addr = (state == uart_bridge_pkg::SET_ADDR) && rx_valid;
  assign p.byte_idx  = cnt[1:0];
  assign p.byte_val  = rx_data;

  assign m.addr  = p.addr.word[`MEM_ADDR_W-1:0] + cnt[`MEM_ADDR_W-1:0]; // wraps at depth
  assign m.wdata = rx_data;
  assign m.wr    = (state == uart_bridge_pkg::WRITE) && rx_valid && !cnt_done;

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      state    <= uart_bridge_pkg::IDLE;
      cnt      <= '0;
      rd_phase <= RD_REQ;
      m.rd     <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      m.rd     <= 1'b0;
      tx_start <= 1'b0;
      case (state)
        uart_bridge_pkg::IDLE: begin
          if (rx_valid) begin
            cnt      <= '0;
            rd_phase <= RD_REQ;
            case (rx_data)
              `CMD_LEN:   state <= uart_bridge_pkg::SET_LEN;
              `CMD_ADDR:  state <= uart_bridge_pkg::SET_ADDR;
              `CMD_READ:  state <= uart_bridge_pkg::READ;
              `CMD_WRITE: state <= uart_bridge_pkg::WRITE;
              default:    state <= uart_bridge_pkg::IDLE; // unknown byte, no reply
            endcase
          end
        end
        uart_bridge_pkg::SET_LEN, uart_bridge_pkg::SET_ADDR: begin
          if (rx_valid) begin
            if (cnt == 32'd3) begin
              state <= uart_bridge_pkg::ACK;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 32'd1;
            end
          end
        end
        uart_bridge_pkg::WRITE: begin
          if (cnt_done) begin
            state <= uart_bridge_pkg::ACK;
            cnt   <= '0;
          end else if (rx_valid) begin
            cnt <= cnt + 32'd1;
          end
        end
        uart_bridge_pkg::READ: begin
          case (rd_phase)
            RD_REQ: begin
              if (cnt_done) begin
                state <= uart_bridge_pkg::ACK;
                cnt   <= '0;
              end else if (tx_free) begin
                m.rd     <= 1'b1;
                rd_phase <= RD_WAIT;
              end
            end
            RD_WAIT: rd_phase <= RD_SEND; // address held by cnt
            default: begin
              tx_start <= 1'b1;
              cnt      <= cnt + 32'd1;
              rd_phase <= RD_REQ;
            end
          endcase
        end
        uart_bridge_pkg::ACK: begin
          if (tx_free) begin
            if (cnt == 32'd3) begin
              state <= uart_bridge_pkg::IDLE; // last ack byte fully sent
            end else begin
              tx_start <= 1'b1;
              cnt      <= cnt + 32'd1;
            end
          end
        end
        default: state <= uart_bridge_pkg::IDLE;
      endcase
    end
  end

  // byte for the transmitter, captured with the start pulse
  always_ff @(posedge clk) begin
    if (state == uart_bridge_pkg::READ && rd_phase == RD_SEND) begin
      tx_data <= m.rdata;
    end else if (state == uart_bridge_pkg::ACK && tx_free) begin
      tx_data <= ack_byte;
    end
  end

endmodule

/* verilog/bus_mem.sv */
// on-chip byte memory on the bridge bus, written and read by the command controller
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

module bus_mem (
  input  logic  clk,
  mem_if.slave  m
);

  localparam int DEPTH = 1 << `MEM_ADDR_W;

  logic [7:0] mem [0:DEPTH-1]; // contents undefined until written

  always_ff @(posedge clk) begin
    if (m.wr) begin
      mem[m.addr] <= m.wdata;
    end
  end

  // registered read, data one cycle after rd
  always_ff @(posedge clk) begin
    if (m.rd) begin
      m.rdata <= mem[m.addr];
    end
  end

endmodule

/* verilog/uart_bridge_top.sv */
// top level of the uart bridge, serial pins in and out, memory kept inside
`timescale 1ns/1ps

module uart_bridge_top (
  input  logic clk,
  input  logic UART_RST,
  input  logic uart_rx,
  output logic uart_tx
);

  logic       rx_valid;
  logic [7:0] rx_data;
  logic       tx_start;
  logic [7:0] tx_data;
  logic       tx_busy;

  param_if p_if ();
  mem_if   m_if ();

  uart_rx u_rx (
    .clk      (clk),
    .UART_RST (UART_RST),
    .rx       (uart_rx),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
  );

  uart_tx u_tx (
    .clk      (clk),
    .UART_RST (UART_RST),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (uart_tx),
    .tx_busy  (tx_busy)
  );

  uart_param_regs u_regs (
    .clk      (clk),
    .UART_RST (UART_RST),
    .p        (p_if.regs)
  );

  uart_cmd_ctrl u_ctrl (
    .clk      (clk),
    .UART_RST (UART_RST),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .p        (p_if.ctrl),
    .m        (m_if.master)
  );

  bus_mem u_mem (
    .clk (clk),
    .m   (m_if.slave)
  );

endmodule

/* tb/uart_bridge_assert.sv */
// concurrent checks on the bridge pins and the command FSM, bound into the design
`timescale 1ns/1ps

module uart_bridge_assert (
  input logic                           clk,
  input logic                           UART_RST,
  input logic                           uart_tx,
  input logic                           wr,
  input logic                           rd,
  input logic                           tx_start,
  input logic                           tx_busy,
  input uart_bridge_pkg::bridge_state_t state
);

  localparam logic [15:0] MAX_BUSY = 16'd2000; // longest command in clocks plus margin

  logic [15:0] busy_cycles;
  bit          pin_err = 1'b0;
  bit          bus_err = 1'b0;
  bit          start_err = 1'b0;
  bit          hang_err = 1'b0;
  logic        err_seen;

  assign err_seen = pin_err | bus_err | start_err | hang_err;

  // cycles spent outside IDLE
  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      busy_cycles <= '0;
    end else if (state == uart_bridge_pkg::IDLE) begin
      busy_cycles <= '0;
    end else begin
      busy_cycles <= busy_cycles + 16'd1;
    end
  end

  tx_high_in_reset: assert property (@(posedge clk) UART_RST |-> uart_tx)
    else begin
      pin_err = 1'b1;
      $error("uart_tx low while in reset");
    end

  wr_rd_exclusive: assert property (@(posedge clk) disable iff (UART_RST) !(wr && rd))
    else begin
      bus_err = 1'b1;
      $error("memory wr and rd high together");
    end

  start_when_idle: assert property (@(posedge clk) disable iff (UART_RST) tx_start |-> !tx_busy)
    else begin
      start_err = 1'b1;
      $error("tx_start while transmitter busy");
    end

  back_to_idle: assert property (@(posedge clk) disable iff (UART_RST) busy_cycles < MAX_BUSY)
    else begin
      hang_err = 1'b1;
      $error("controller did not return to IDLE in time");
    end

endmodule

// one checker at the top sees the serial pin, the memory bus and the controller FSM
bind uart_bridge_top uart_bridge_assert u_chk (
  .clk      (clk),
  .UART_RST (UART_RST),
  .uart_tx  (uart_tx),
  .wr       (m_if.wr),
  .rd       (m_if.rd),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .state    (u_ctrl.state)
);

/* tb/tb_uart_bridge.sv */
// testbench of the uart bridge, a serial host model against a scoreboard of expected replies
`timescale 1ns/1ps
`include "uart_bridge_consts.svh"

module tb_uart_bridge;

  localparam int OVS       = `UART_OVERSAMPLE;
  localparam int MEM_DEPTH = 1 << `MEM_ADDR_W;

  logic        clk;
  logic        UART_RST;
  logic        uart_rx;
  logic        uart_tx;
  logic        chk_err;
  logic [7:0]  reply_q [$];            // bytes decoded from uart_tx
  logic [7:0]  model_mem [0:MEM_DEPTH-1];
  bit          model_known [0:MEM_DEPTH-1];
  logic [31:0] cur_len;
  logic [31:0] cur_addr;
  logic [31:0] rng;

  uart_bridge_top dut (
    .clk      (clk),
    .UART_RST (UART_RST),
    .uart_rx  (uart_rx),
    .uart_tx  (uart_tx)
  );

  assign chk_err = dut.u_chk.err_seen;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("%s (t=%0t)", what, $time);
    stop_run();
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected=%02h actual=%02h", $time, name, exp, act);
      stop_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // host side sends one frame lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (OVS - 1) @(posedge clk);
    end
  endtask

  task automatic wait_replies(input int n);
    int cycles;
    cycles = 0;
    while (reply_q.size() < n) begin
      @(posedge clk);
      cycles++;
      if (cycles > 60 * (n + 4)) begin
        report_problem("timeout waiting for reply bytes on uart_tx");
      end
    end
  endtask

  task automatic check_ack();
    wait_replies(3);
    check_byte("uart_tx ack byte 0", `ACK_0, reply_q.pop_front());
    check_byte("uart_tx ack byte 1", `ACK_1, reply_q.pop_front());
    check_byte("uart_tx ack byte 2", `ACK_2, reply_q.pop_front());
    if (reply_q.size() != 0) begin
      report_problem("extra bytes on uart_tx after the acknowledgement");
    end
  endtask

  task automatic set_param(input logic [7:0] cmd, input logic [31:0] value);
    send_byte(cmd);
    for (int i = 0; i < 4; i++) begin
      send_byte(value[8*i +: 8]);
    end
    check_ack();
  endtask

  task automatic write_block();
    int idx;
    logic [7:0] b;
    send_byte(`CMD_WRITE);
    for (int i = 0; i < int'(cur_len); i++) begin
      rng = xorshift32(rng);
      b = rng[7:0];
      idx = (int'(cur_addr) + i) % MEM_DEPTH; // wraps at depth
      model_mem[idx] = b;
      model_known[idx] = 1'b1;
      send_byte(b);
    end
    check_ack();
  endtask

  task automatic read_block();
    int n;
    int idx;
    logic [7:0] act;
    n = int'(cur_len);
    send_byte(`CMD_READ);
    wait_replies(n + 3);
    for (int i = 0; i < n; i++) begin
      idx = (int'(cur_addr) + i) % MEM_DEPTH;
      act = reply_q.pop_front();
      if (model_known[idx]) begin
        check_byte("uart_tx read data", model_mem[idx], act);
      end
    end
    check_ack();
  endtask

  // line must stay high with nothing received
  task automatic expect_silence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      check_byte("uart_tx", 8'h01, {7'd0, uart_tx});
    end
    if (reply_q.size() != 0) begin
      report_problem("unexpected byte received on uart_tx");
    end
  endtask

  // decodes reply frames at mid-bit
  initial begin : tx_monitor
    logic       prev;
    logic [7:0] b;
    prev = 1'b1;
    forever begin
      @(posedge clk);
      if (UART_RST !== 1'b1 && prev && !uart_tx) begin
        repeat (OVS / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (OVS) @(posedge clk);
          b[i] = uart_tx;
        end
        repeat (OVS) @(posedge clk);
        if (uart_tx !== 1'b1) begin
          report_problem("stop bit low on uart_tx");
        end
        reply_q.push_back(b);
      end
      prev = uart_tx;
    end
  end

  always @(posedge clk) begin
    if (chk_err) begin
      report_problem("a bound assertion fired in the DUT");
    end
  end

  initial begin : main_seq
    uart_rx  <= 1'b1;
    UART_RST <= 1'b1;
    rng      = 32'h03ef_ec33;
    cur_len  = 32'd1; // reset values of the bridge
    cur_addr = 32'd0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      model_known[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    UART_RST <= 1'b0;

    expect_silence(100);
    read_block();             // one byte from the reset length

    cur_len = 32'd5;
    set_param(`CMD_LEN, cur_len);
    cur_addr = 32'h10;
    set_param(`CMD_ADDR, cur_addr);
    write_block();
    read_block();

    cur_addr = 32'hfe;        // block crosses the top of memory
    set_param(`CMD_ADDR, cur_addr);
    cur_len = 32'd4;
    set_param(`CMD_LEN, cur_len);
    write_block();
    read_block();

    cur_addr = 32'h0;         // wrapped bytes sit at the bottom
    set_param(`CMD_ADDR, cur_addr);
    read_block();

    send_byte(8'h5a);         // not a command
    expect_silence(200);
    read_block();

    cur_len = 32'd0;
    set_param(`CMD_LEN, cur_len);
    read_block();
    write_block();

    expect_silence(100);
    if (chk_err) begin
      report_problem("a bound assertion fired in the DUT");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+verilog
verilog/uart_bridge_pkg.sv
verilog/uart_bridge_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_param_regs.sv
verilog/uart_cmd_ctrl.sv
verilog/bus_mem.sv
verilog/uart_bridge_top.sv
tb/uart_bridge_assert.sv
tb/tb_uart_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# build the uart bridge testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_uart_bridge -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended abnormally (status $status)"
  exit 1
fi
